//--- src/vid_dma_pkg.sv
`default_nettype none

package vid_dma_pkg;

  ////////////////////////////////////////////////////////////
  // stream geometry
  ////////////////////////////////////////////////////////////
  localparam int PIX_W        = 16;  // rgb565
  localparam int BEAT_W       = 128;
  localparam int PIX_PER_BEAT = BEAT_W / PIX_W;  // 8
  localparam int BURST_BEATS  = 4;  // payload beats per mwr
  localparam int BURST_BYTES  = BURST_BEATS * BEAT_W / 8;  // 64
  localparam int BURST_DW     = BURST_BYTES / 4;  // tlp length field
  localparam int FIFO_DEPTH   = 16;

  localparam int PIX_IDX_W  = $clog2(PIX_PER_BEAT);
  localparam int BEAT_CNT_W = $clog2(BURST_BEATS);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam int RST_HOLD_CYCLES = 64;

  ////////////////////////////////////////////////////////////
  // pcie constants
  ////////////////////////////////////////////////////////////
  localparam logic [31:0] FRAME_BASE   = 32'h1000_0000;  // 64-byte aligned
  localparam logic [7:0]  MWR_FMT_TYPE = 8'h40;  // 3dw header with data

  typedef struct packed {
    logic       vs;
    logic       hs;
    logic       de;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } video_t;

  typedef struct packed {
    logic             valid;
    logic             sof;  // first pixel of a frame
    logic [PIX_W-1:0] rgb;
  } pix_t;

  typedef struct packed {
    logic              sof;
    logic [BEAT_W-1:0] data;  // pixel 0 in bits 15:0
  } beat_t;

  typedef struct packed {
    logic [BEAT_W-1:0] data;
    logic              last;
  } stream_t;

endpackage

`default_nettype wire

//--- src/rst_hold.sv
`timescale 1ns/1ps
`default_nettype none

// holds the video path off until the output chips have settled
module rst_hold #(
  parameter int HOLD_CYCLES = 64
) (
  input  wire  cfg_clk,
  input  wire  rst_n,
  output logic video_ready
);

  localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

  logic [CNT_W-1:0] hold_cnt;

  always_ff @(posedge cfg_clk) begin
    if (!rst_n) begin
      hold_cnt <= '0;
    end else if (hold_cnt != CNT_W'(HOLD_CYCLES)) begin
      hold_cnt <= hold_cnt + 1'b1;  // saturates at HOLD_CYCLES
    end
  end

  assign video_ready = (hold_cnt == CNT_W'(HOLD_CYCLES));

endmodule

`default_nettype wire

//--- src/vid_capture.sv
`timescale 1ns/1ps
`default_nettype none

module vid_capture (
  input  wire                 cfg_clk,
  input  wire                 rst_n,
  input  wire                 video_ready,
  input  vid_dma_pkg::video_t video_in,
  output vid_dma_pkg::video_t video_out,
  output vid_dma_pkg::pix_t   pix
);

  logic                          vs_prev;
  logic                          sof_armed;
  logic                          pix_valid_q;
  logic                          pix_sof_q;
  logic [vid_dma_pkg::PIX_W-1:0] rgb_q;
  logic                          vs_rise;

  assign vs_rise = video_in.vs & ~vs_prev;

  ////////////////////////////////////////////////////////////
  // passthrough
  ////////////////////////////////////////////////////////////
  always_ff @(posedge cfg_clk) begin
    if (!rst_n || !video_ready) begin
      video_out <= '0;  // quiet output until ready
    end else begin
      video_out <= video_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // pixel tap
  ////////////////////////////////////////////////////////////
  always_ff @(posedge cfg_clk) begin
    if (!rst_n) begin
      vs_prev     <= 1'b0;
      sof_armed   <= 1'b0;
      pix_valid_q <= 1'b0;
      pix_sof_q   <= 1'b0;
    end else begin
      vs_prev     <= video_in.vs;
      pix_valid_q <= video_ready & video_in.de;
      if (!video_ready) begin
        sof_armed <= 1'b0;
      end else if (video_in.de) begin
        pix_sof_q <= sof_armed | vs_rise;
        sof_armed <= 1'b0;  // only the first de pixel
      end else if (vs_rise) begin
        sof_armed <= 1'b1;
      end
    end
  end

  always_ff @(posedge cfg_clk) begin
    rgb_q <= {video_in.r[7:3], video_in.g[7:2], video_in.b[7:3]};  // 5-6-5 truncation
  end

  assign pix = '{valid: pix_valid_q, sof: pix_sof_q, rgb: rgb_q};

endmodule

`default_nettype wire

//--- src/pix_packer.sv
`timescale 1ns/1ps
`default_nettype none

module pix_packer (
  input  wire                cfg_clk,
  input  wire                rst_n,
  input  vid_dma_pkg::pix_t  pix,
  output vid_dma_pkg::beat_t beat,
  output logic               beat_valid
);

  localparam logic [vid_dma_pkg::PIX_IDX_W-1:0] LAST_IDX =
    vid_dma_pkg::PIX_IDX_W'(vid_dma_pkg::PIX_PER_BEAT - 1);

  logic [vid_dma_pkg::BEAT_W-1:0]    data_q;
  logic [vid_dma_pkg::PIX_IDX_W-1:0] idx_q;
  logic                              grp_sof_q;
  logic                              beat_valid_q;

  ////////////////////////////////////////////////////////////
  // group tracking
  ////////////////////////////////////////////////////////////
  always_ff @(posedge cfg_clk) begin
    if (!rst_n) begin
      idx_q        <= '0;
      grp_sof_q    <= 1'b0;
      beat_valid_q <= 1'b0;
    end else begin
      beat_valid_q <= 1'b0;
      if (pix.valid) begin
        if (pix.sof) begin
          // new frame restarts the group, partial one is dropped
          idx_q     <= vid_dma_pkg::PIX_IDX_W'(1);
          grp_sof_q <= 1'b1;
        end else if (idx_q == LAST_IDX) begin
          idx_q        <= '0;
          beat_valid_q <= 1'b1;  // eighth pixel just entered
        end else begin
          if (idx_q == '0) begin
            grp_sof_q <= 1'b0;  // plain group start
          end
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  // shift right so the oldest pixel lands in the low bits
  always_ff @(posedge cfg_clk) begin
    if (pix.valid) begin
      data_q <= {pix.rgb, data_q[vid_dma_pkg::BEAT_W-1:vid_dma_pkg::PIX_W]};
    end
  end

  assign beat       = '{sof: grp_sof_q, data: data_q};
  assign beat_valid = beat_valid_q;

endmodule

`default_nettype wire

//--- src/beat_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module beat_fifo #(
  parameter int DEPTH = vid_dma_pkg::FIFO_DEPTH
) (
  input  wire                          cfg_clk,
  input  wire                          rst_n,
  input  vid_dma_pkg::beat_t           wr_beat,
  input  wire                          wr_en,
  input  wire                          rd_en,
  output vid_dma_pkg::beat_t           rd_beat,
  output logic                         rd_valid,
  output logic [$clog2(DEPTH+1)-1:0]   count,
  output logic                         overrun
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  vid_dma_pkg::beat_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          full;
  logic          do_wr;
  logic          do_rd;

  assign full  = (count == CW'(DEPTH));
  assign do_wr = wr_en & ~full;  // no ready on the write side
  assign do_rd = rd_en & rd_valid;

  always_ff @(posedge cfg_clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      overrun <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (wr_en && full) begin
        overrun <= 1'b1;  // sticky until reset
      end
    end
  end

  always_ff @(posedge cfg_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  assign rd_beat  = mem[rd_ptr];  // head, valid when count != 0
  assign rd_valid = (count != '0);

endmodule

`default_nettype wire

//--- src/tlp_writer.sv
`timescale 1ns/1ps
`default_nettype none

module tlp_writer (
  input  wire                                  cfg_clk,
  input  wire                                  rst_n,
  input  wire  [7:0]                           ep_bus_num,
  input  wire  [4:0]                           ep_dev_num,
  input  vid_dma_pkg::beat_t                   rd_beat,
  input  wire                                  rd_valid,
  input  wire  [vid_dma_pkg::FIFO_CNT_W-1:0]   count,
  output logic                                 rd_en,
  output vid_dma_pkg::stream_t                 tx,
  output logic                                 tx_valid,
  input  wire                                  tx_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HDR,
    ST_PAY
  } state_t;

  localparam logic [vid_dma_pkg::BEAT_CNT_W-1:0] LAST_BEAT =
    vid_dma_pkg::BEAT_CNT_W'(vid_dma_pkg::BURST_BEATS - 1);

  state_t                             state;
  logic [31:0]                        addr_q;
  logic [31:0]                        addr_next;
  logic [vid_dma_pkg::BEAT_CNT_W-1:0] beat_cnt;
  logic [vid_dma_pkg::BEAT_W-1:0]     hdr_q;
  logic [vid_dma_pkg::BEAT_W-1:0]     hdr_data;
  logic [31:0]                        hdr_dw0;
  logic [31:0]                        hdr_dw1;
  logic                               burst_ready;
  logic                               last_beat;
  logic                               xfer;

  ////////////////////////////////////////////////////////////
  // header fields
  ////////////////////////////////////////////////////////////
  // a full burst waits in the fifo, so payload never stalls on empty
  assign burst_ready = rd_valid &&
                       (count >= vid_dma_pkg::FIFO_CNT_W'(vid_dma_pkg::BURST_BEATS));

  assign addr_next = rd_beat.sof ? vid_dma_pkg::FRAME_BASE :
                     addr_q + 32'(vid_dma_pkg::BURST_BYTES);

  assign hdr_dw0 = {vid_dma_pkg::MWR_FMT_TYPE, 14'h0, 10'(vid_dma_pkg::BURST_DW)};
  assign hdr_dw1 = {ep_bus_num, ep_dev_num, 3'b000,  // requester id, function 0
                    8'h00,                            // tag
                    8'hFF};                           // last/first byte enables
  assign hdr_data = {32'h0, addr_next, hdr_dw1, hdr_dw0};

  ////////////////////////////////////////////////////////////
  // packet FSM
  ////////////////////////////////////////////////////////////
  assign xfer = tx_valid & tx_ready;

  always_ff @(posedge cfg_clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      addr_q   <= vid_dma_pkg::FRAME_BASE;
      beat_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (burst_ready) begin
            addr_q <= addr_next;  // peeked from head sof
            state  <= ST_HDR;
          end
        end
        ST_HDR: begin
          if (xfer) begin
            beat_cnt <= '0;
            state    <= ST_PAY;
          end
        end
        ST_PAY: begin
          if (xfer) begin
            if (last_beat) begin
              state <= ST_IDLE;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // header beat held here until it transfers
  always_ff @(posedge cfg_clk) begin
    if (state == ST_IDLE && burst_ready) begin
      hdr_q <= hdr_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // stream output
  ////////////////////////////////////////////////////////////
  assign last_beat = (beat_cnt == LAST_BEAT);

  always_comb begin
    case (state)
      ST_PAY:  tx = '{data: rd_beat.data, last: last_beat};  // fifo head
      default: tx = '{data: hdr_q, last: 1'b0};
    endcase
  end

  assign tx_valid = (state == ST_HDR) || (state == ST_PAY && rd_valid);
  assign rd_en    = (state == ST_PAY) && rd_valid && tx_ready;  // pop on transfer

endmodule

`default_nettype wire

//--- src/vid_dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module vid_dma_top (
  input  wire                  cfg_clk,
  input  wire                  rst_n,
  input  vid_dma_pkg::video_t  video_in,
  output vid_dma_pkg::video_t  video_out,
  input  wire  [7:0]           ep_bus_num,
  input  wire  [4:0]           ep_dev_num,
  output vid_dma_pkg::stream_t tx,
  output logic                 tx_valid,
  input  wire                  tx_ready,
  output logic                 overrun,
  output logic                 video_ready
);

  vid_dma_pkg::pix_t                  pix;
  vid_dma_pkg::beat_t                 beat;
  logic                               beat_valid;
  vid_dma_pkg::beat_t                 rd_beat;
  logic                               rd_valid;
  logic                               rd_en;
  logic [vid_dma_pkg::FIFO_CNT_W-1:0] count;

  ////////////////////////////////////////////////////////////
  // video side
  ////////////////////////////////////////////////////////////
  rst_hold #(
    .HOLD_CYCLES (vid_dma_pkg::RST_HOLD_CYCLES)
  ) rst_hold_i (
    .cfg_clk     (cfg_clk),
    .rst_n       (rst_n),
    .video_ready (video_ready)
  );

  vid_capture vid_capture_i (
    .cfg_clk     (cfg_clk),
    .rst_n       (rst_n),
    .video_ready (video_ready),
    .video_in    (video_in),
    .video_out   (video_out),
    .pix         (pix)
  );

  pix_packer pix_packer_i (
    .cfg_clk    (cfg_clk),
    .rst_n      (rst_n),
    .pix        (pix),
    .beat       (beat),
    .beat_valid (beat_valid)
  );

  ////////////////////////////////////////////////////////////
  // pcie side
  ////////////////////////////////////////////////////////////
  beat_fifo #(
    .DEPTH (vid_dma_pkg::FIFO_DEPTH)
  ) beat_fifo_i (
    .cfg_clk  (cfg_clk),
    .rst_n    (rst_n),
    .wr_beat  (beat),
    .wr_en    (beat_valid),
    .rd_en    (rd_en),
    .rd_beat  (rd_beat),
    .rd_valid (rd_valid),
    .count    (count),
    .overrun  (overrun)
  );

  tlp_writer tlp_writer_i (
    .cfg_clk    (cfg_clk),
    .rst_n      (rst_n),
    .ep_bus_num (ep_bus_num),
    .ep_dev_num (ep_dev_num),
    .rd_beat    (rd_beat),
    .rd_valid   (rd_valid),
    .count      (count),
    .rd_en      (rd_en),
    .tx         (tx),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready)
  );

endmodule

`default_nettype wire

//--- dv/vid_dma_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vid_dma_tb;

  logic                 cfg_clk;
  logic                 rst_n;
  vid_dma_pkg::video_t  video_in;
  vid_dma_pkg::video_t  video_out;
  logic [7:0]           ep_bus_num;
  logic [4:0]           ep_dev_num;
  vid_dma_pkg::stream_t tx;
  logic                 tx_valid;
  logic                 tx_ready;
  logic                 overrun;
  logic                 video_ready;

  integer               seed;
  int                   errors;
  logic                 mon_on;
  logic                 data_check;  // off once beats get dropped
  logic                 ready_hold;
  logic                 ready_level;
  logic [31:0]          sink_rnd;
  logic [127:0]         exp_beats[$];
  logic                 exp_sof[$];
  int                   pkt_pos;  // 0 = header expected
  logic [31:0]          last_addr;
  vid_dma_pkg::video_t  prev_in;
  logic                 prev_ready;
  logic                 hold_tx;
  vid_dma_pkg::stream_t held_tx;
  logic                 ready_seen;
  logic                 ovr_seen;

  vid_dma_top dut_i (
    .cfg_clk     (cfg_clk),
    .rst_n       (rst_n),
    .video_in    (video_in),
    .video_out   (video_out),
    .ep_bus_num  (ep_bus_num),
    .ep_dev_num  (ep_dev_num),
    .tx          (tx),
    .tx_valid    (tx_valid),
    .tx_ready    (tx_ready),
    .overrun     (overrun),
    .video_ready (video_ready)
  );

  always #5 cfg_clk = ~cfg_clk;

  always @(posedge cfg_clk) begin
    if (ready_hold) begin
      tx_ready <= ready_level;
    end else begin
      sink_rnd = $random(seed);
      tx_ready <= sink_rnd[0];  // random back-pressure
    end
  end

  task automatic report_mismatch(input string msg);
    errors++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic finish_run();
    $display("run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    report_error($sformatf("timeout while waiting for %s", what));
  endtask

  ////////////////////////////////////////////////////////////
  // packet checker
  ////////////////////////////////////////////////////////////
  task automatic check_beat(input vid_dma_pkg::stream_t b);
    logic [31:0]  exp_addr;
    logic [127:0] exp_data;
    if (pkt_pos == 0) begin
      assert (b.data[31:24] == vid_dma_pkg::MWR_FMT_TYPE && b.data[23:0] == 24'd16)
        else report_mismatch($sformatf("header dword 0 %h", b.data[31:0]));
      assert (b.data[63:32] == {ep_bus_num, ep_dev_num, 3'b000, 8'h00, 8'hff})
        else report_mismatch($sformatf("header dword 1 %h", b.data[63:32]));
      assert (b.data[127:96] == 32'h0 && !b.last)
        else report_mismatch("header dword 3 or last not zero");
      if (data_check) begin
        if (exp_sof.size() == 0) begin
          report_error("header sent with no payload pending");
        end else begin
          exp_addr = exp_sof[0] ? vid_dma_pkg::FRAME_BASE : last_addr + 32'd64;
          assert (b.data[95:64] == exp_addr)
            else report_mismatch($sformatf("address %h expected %h", b.data[95:64], exp_addr));
          last_addr = exp_addr;
        end
      end
    end else begin
      assert (b.last == (pkt_pos == vid_dma_pkg::BURST_BEATS))
        else report_mismatch($sformatf("last %b on payload beat %0d", b.last, pkt_pos));
      if (data_check) begin
        if (exp_beats.size() == 0) begin
          report_error("payload beat arrived that no pixels account for");
        end else begin
          exp_data = exp_beats.pop_front();
          void'(exp_sof.pop_front());
          assert (b.data == exp_data)
            else report_mismatch($sformatf("payload %h expected %h", b.data, exp_data));
        end
      end
    end
    pkt_pos = (pkt_pos == vid_dma_pkg::BURST_BEATS) ? 0 : pkt_pos + 1;
  endtask

  // outputs are sampled mid-cycle, away from the driving edge
  always @(negedge cfg_clk) begin
    if (mon_on) begin
      if (prev_ready) begin
        assert (video_out == prev_in)
          else report_mismatch($sformatf("video_out %h expected %h", video_out, prev_in));
      end else begin
        assert (video_out == '0) else report_mismatch("video_out not zero before ready");
      end
      if (hold_tx) begin
        assert (tx_valid && tx == held_tx) else report_mismatch("tx changed while stalled");
      end
      if (ready_seen) begin
        assert (video_ready) else report_mismatch("video_ready dropped");
      end
      if (ovr_seen) begin
        assert (overrun) else report_mismatch("overrun cleared");
      end
      if (tx_valid && tx_ready) begin
        check_beat(tx);
      end
      ready_seen = ready_seen | video_ready;
      ovr_seen   = ovr_seen | overrun;
    end
    prev_in    = video_in;
    prev_ready = video_ready;
    hold_tx    = tx_valid && !tx_ready;
    held_tx    = tx;
  end

  ////////////////////////////////////////////////////////////
  // video source
  ////////////////////////////////////////////////////////////
  task automatic drive_idle(input logic vs, input logic hs, input int n);
    repeat (n) begin
      @(posedge cfg_clk);
      video_in <= '{vs: vs, hs: hs, de: 1'b0, r: 8'h0, g: 8'h0, b: 8'h0};
    end
  endtask

  task automatic send_frame();
    int           px;
    logic [31:0]  r;
    logic [127:0] acc;
    logic         first;
    first = 1'b1;
    acc   = '0;
    drive_idle(1'b1, 1'b0, 2);  // vs pulse
    drive_idle(1'b0, 1'b0, 3);
    for (px = 0; px < 4 * 32; px++) begin
      if (px % 32 == 0) begin
        drive_idle(1'b0, 1'b1, 2);  // hs, then back porch
        drive_idle(1'b0, 1'b0, 2);
      end
      r = $random(seed);
      @(posedge cfg_clk);
      video_in <= '{vs: 1'b0, hs: 1'b0, de: 1'b1, r: r[23:16], g: r[15:8], b: r[7:0]};
      acc[16 * (px % 8) +: 16] = {r[23:19], r[15:10], r[7:3]};  // keep upper bits
      if (px % 8 == 7 && data_check) begin
        exp_beats.push_back(acc);
        exp_sof.push_back(first);
        first = 1'b0;
      end
      if (px % 32 == 31) begin
        drive_idle(1'b0, 1'b0, 4);
      end
    end
  endtask

  task automatic check_hold_time(output logic ok);
    int          cycles;
    logic [31:0] r;
    cycles = 0;
    @(negedge cfg_clk);
    assert (!video_ready && !tx_valid && !overrun) else report_mismatch("outputs high after reset");
    while (!video_ready && cycles < 4 * vid_dma_pkg::RST_HOLD_CYCLES) begin
      cycles++;
      @(posedge cfg_clk);
      r = $random(seed);
      video_in <= '{vs: 1'b0, hs: r[24], de: 1'b0, r: r[7:0], g: r[15:8], b: r[23:16]};
      @(negedge cfg_clk);
    end
    if (!video_ready) begin
      timed_out("video_ready");
      ok = 1'b0;
    end else begin
      ok = 1'b1;
      assert (cycles == vid_dma_pkg::RST_HOLD_CYCLES)
        else report_mismatch($sformatf("video_ready after %0d cycles", cycles));
    end
  endtask

  task automatic run_sequence();
    int   n;
    int   quiet;
    logic ok;
    check_hold_time(ok);
    if (!ok) begin
      return;
    end

    repeat (3) send_frame();
    n = 0;
    while ((exp_beats.size() != 0 || pkt_pos != 0) && n < 5000) begin
      @(negedge cfg_clk);
      n++;
    end
    if (exp_beats.size() != 0 || pkt_pos != 0) begin
      timed_out("the frames to drain");
      return;
    end
    assert (!overrun) else report_mismatch("overrun under random ready");

    // stall the sink until the FIFO overflows
    data_check  = 1'b0;
    ready_hold  = 1'b1;
    ready_level = 1'b0;
    repeat (2) send_frame();
    n = 0;
    while (!overrun && n < 200) begin
      @(negedge cfg_clk);
      n++;
    end
    if (!overrun) begin
      timed_out("overrun");
      return;
    end
    ready_level = 1'b1;
    n     = 0;
    quiet = 0;
    while (quiet < 32 && n < 2000) begin
      @(negedge cfg_clk);
      quiet = tx_valid ? 0 : quiet + 1;
      n++;
    end
    if (quiet < 32) begin
      timed_out("the stream to go idle");
      return;
    end
    assert (pkt_pos == 0) else report_mismatch("packet cut short after overrun");
    assert (overrun) else report_mismatch("overrun not held");
  endtask

  initial begin
    seed        = 32'he248;
    errors      = 0;
    mon_on      = 1'b0;
    data_check  = 1'b1;
    ready_hold  = 1'b0;
    ready_level = 1'b0;
    pkt_pos     = 0;
    last_addr   = vid_dma_pkg::FRAME_BASE;
    ready_seen  = 1'b0;
    ovr_seen    = 1'b0;
    cfg_clk     = 1'b0;
    rst_n       = 1'b0;
    video_in    = '0;
    ep_bus_num  = 8'h3a;
    ep_dev_num  = 5'h11;
    tx_ready    = 1'b0;
    repeat (2) @(posedge cfg_clk);
    rst_n  <= 1'b1;
    mon_on = 1'b1;
    run_sequence();
    finish_run();
  end

endmodule

`default_nettype wire

//--- vid_dma.f
src/vid_dma_pkg.sv
src/rst_hold.sv
src/vid_capture.sv
src/pix_packer.sv
src/beat_fifo.sv
src/tlp_writer.sv
src/vid_dma_top.sv
dv/vid_dma_tb.sv
